// ==== rtl/cart_pkg.sv ====
`default_nettype none

package cart_pkg;

	typedef enum logic [1:0] {
		JP = 2'd0,
		US = 2'd1,
		EU = 2'd2
	} region_t;

	// Search order used when the header names more than one region
	typedef enum logic [1:0] {
		PRIO_UEJ = 2'd0, // US > EU > JP
		PRIO_EUJ = 2'd1, // EU > US > JP
		PRIO_UJE = 2'd2, // US > JP > EU
		PRIO_JUE = 2'd3  // JP > US > EU
	} region_prio_t;

	typedef struct packed {
		logic hdr_j;
		logic hdr_u;
		logic hdr_e;
	} hdr_flags_t;

	typedef logic [63:0] product_id_t; // Eight ASCII chars, first one on top
	typedef logic [7:0]  gun_delay_t;

	typedef struct packed {
		logic sram;
		logic eeprom;
		logic noram;
		logic fifo;
		logic svp;
		logic gun_type;
	} quirks_t;

	typedef struct packed {
		logic [31:0] flags;
		logic [31:0] address;
		logic [31:0] compare;
		logic [31:0] replace;
	} cheat_code_t;

	localparam logic [9:0] HDR_REGION_ADDR   = 10'h1F0;
	localparam logic [9:0] HDR_REGION2_ADDR  = 10'h1F2;
	localparam logic [9:0] HDR_ID_FIRST_ADDR = 10'h182;
	localparam logic [9:0] HDR_ID_DONE_ADDR  = 10'h18C;
	localparam logic [9:0] HDR_END_ADDR      = 10'h200;

	localparam gun_delay_t GUN_DELAY_DEFAULT = 8'd44;
	localparam logic [7:0] CODE_INDEX        = 8'hFF; // Cheat stream marker

endpackage

`default_nettype wire

// ==== rtl/rom_bus_pkg.sv ====
`default_nettype none

package rom_bus_pkg;

	typedef logic [15:0] word_t;
	typedef logic [1:0]  sel_t;

	// Wishbone classic, write side only
	typedef struct packed {
		logic  cyc;
		logic  stb;
		logic  we;
		sel_t  sel;
		word_t dat;
	} wb_wr_req_t;

endpackage

`default_nettype wire

// ==== rtl/cart_load_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module cart_load_ctrl #(
	parameter int ADDR_W = 25
) (
	input  logic                   clk_sys,
	input  logic                   RESET,
	input  logic                   dl_active,
	input  logic [7:0]             dl_index,
	input  logic                   dl_wr,
	input  logic [ADDR_W-1:0]      dl_addr,
	input  logic                   wr_done,
	input  logic                   hdr_ready,
	input  cart_pkg::hdr_flags_t   hdr_flags,
	input  logic                   region_auto,
	input  cart_pkg::region_t      region_manual,
	input  cart_pkg::region_prio_t region_prio,
	output logic                   dl_wait,
	output logic                   rom_wr_stb,
	output logic                   hdr_wr_stb,
	output logic                   code_wr_stb,
	output logic                   cart_start,
	output logic [ADDR_W-1:0]      rom_size,
	output cart_pkg::region_t      region,
	output logic                   region_set
);

	logic              code_stream;
	logic              cart_dl;
	logic              cart_dl_q;
	logic              hdr_ready_q;
	logic [ADDR_W-1:0] last_addr;

	// First flagged region in the given order, else the head of that order
	function automatic cart_pkg::region_t pick_region(input cart_pkg::region_prio_t prio,
			input cart_pkg::hdr_flags_t f);
		cart_pkg::region_t r;
		r = cart_pkg::US;
		case (prio)
			cart_pkg::PRIO_UEJ: begin
				if (f.hdr_u) r = cart_pkg::US;
				else if (f.hdr_e) r = cart_pkg::EU;
				else if (f.hdr_j) r = cart_pkg::JP;
			end
			cart_pkg::PRIO_EUJ: begin
				if (f.hdr_e) r = cart_pkg::EU;
				else if (f.hdr_u) r = cart_pkg::US;
				else if (f.hdr_j) r = cart_pkg::JP;
				else r = cart_pkg::EU;
			end
			cart_pkg::PRIO_UJE: begin
				if (f.hdr_u) r = cart_pkg::US;
				else if (f.hdr_j) r = cart_pkg::JP;
				else if (f.hdr_e) r = cart_pkg::EU;
			end
			default: begin // JP > US > EU
				if (f.hdr_j) r = cart_pkg::JP;
				else if (f.hdr_u) r = cart_pkg::US;
				else if (f.hdr_e) r = cart_pkg::EU;
				else r = cart_pkg::JP;
			end
		endcase
		return r;
	endfunction

	////////////////////////////////////////////////////////////
	// Stream decode

	assign code_stream = (dl_index == cart_pkg::CODE_INDEX);
	assign cart_dl     = dl_active & ~code_stream;
	assign cart_start  = cart_dl & ~cart_dl_q;

	assign rom_wr_stb  = dl_wr & cart_dl;
	assign hdr_wr_stb  = dl_wr & cart_dl;
	assign code_wr_stb = dl_wr & dl_active & code_stream;

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			dl_wait     <= 1'b0;
			cart_dl_q   <= 1'b0;
			hdr_ready_q <= 1'b0;
			region_set  <= 1'b0;
			region      <= cart_pkg::JP;
		end else begin
			cart_dl_q   <= cart_dl;
			hdr_ready_q <= hdr_ready;

			if (rom_wr_stb)
				dl_wait <= 1'b1; // Hold host until memory acks
			else if (wr_done)
				dl_wait <= 1'b0;

			if (hdr_ready && !hdr_ready_q) begin
				region_set <= 1'b1;
				if (region_auto)
					region <= pick_region(region_prio, hdr_flags);
				else
					region <= region_manual;
			end else if (!hdr_ready && hdr_ready_q) begin
				region_set <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk_sys) begin
		if (rom_wr_stb)
			last_addr <= dl_addr;
		if (cart_dl_q && !cart_dl)
			rom_size <= last_addr; // End of cartridge download
	end

	// Host must respect the wait raised from the bus side
	a_no_wr_in_wait: assert property (@(posedge clk_sys) disable iff (RESET)
		dl_wr |-> !dl_wait);

endmodule

`default_nettype wire

// ==== rtl/cart_header_scan.sv ====
`timescale 1ns/1ps
`default_nettype none

module cart_header_scan #(
	parameter int ADDR_W = 25
) (
	input  logic                  clk_sys,
	input  logic                  RESET,
	input  logic                  hdr_wr_stb,
	input  logic [ADDR_W-1:0]     dl_addr,
	input  rom_bus_pkg::word_t    dl_data,
	input  logic                  cart_start,
	input  logic                  dl_active,
	output cart_pkg::hdr_flags_t  hdr_flags,
	output cart_pkg::product_id_t product_id,
	output logic                  id_done,
	output logic                  hdr_ready
);

	logic [7:0]           lo;
	logic [7:0]           hi;
	logic [3:0]           hrgn;
	cart_pkg::hdr_flags_t flags_nxt;

	function automatic logic is_letter(input logic [7:0] c);
		return (c == "J") || (c == "U") || (c == "E");
	endfunction

	function automatic cart_pkg::hdr_flags_t mark_letter(input cart_pkg::hdr_flags_t f,
			input logic [7:0] c);
		cart_pkg::hdr_flags_t r;
		r = f;
		if (c == "J") r.hdr_j = 1'b1;
		if (c == "U") r.hdr_u = 1'b1;
		if (c == "E") r.hdr_e = 1'b1;
		return r;
	endfunction

	assign lo   = dl_data[7:0];
	assign hi   = dl_data[15:8];
	assign hrgn = dl_data[3:0] - 4'd7; // 'A'..'F' low nibble to 10..15

	always_comb begin
		flags_nxt = hdr_flags;
		if (dl_addr == ADDR_W'(cart_pkg::HDR_REGION_ADDR)) begin
			if (is_letter(lo)) begin
				flags_nxt = mark_letter(flags_nxt, lo);
			end else if (lo >= "0" && lo <= "9") begin
				flags_nxt.hdr_e = lo[3];
				flags_nxt.hdr_u = lo[2];
				flags_nxt.hdr_j = lo[0];
			end else if (lo >= "A" && lo <= "F") begin
				flags_nxt.hdr_e = hrgn[3];
				flags_nxt.hdr_u = hrgn[2];
				flags_nxt.hdr_j = hrgn[0];
			end
			flags_nxt = mark_letter(flags_nxt, hi); // Second region char
		end else if (dl_addr == ADDR_W'(cart_pkg::HDR_REGION2_ADDR)) begin
			flags_nxt = mark_letter(flags_nxt, lo);
		end
	end

	// ID fully captured by the time 0x18C arrives
	assign id_done = hdr_wr_stb && (dl_addr == ADDR_W'(cart_pkg::HDR_ID_DONE_ADDR));

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			hdr_flags <= '0;
			hdr_ready <= 1'b0;
		end else begin
			if (cart_start)
				hdr_flags <= '0;
			else if (hdr_wr_stb)
				hdr_flags <= flags_nxt;

			if (!dl_active)
				hdr_ready <= 1'b0;
			else if (hdr_wr_stb && dl_addr == ADDR_W'(cart_pkg::HDR_END_ADDR))
				hdr_ready <= 1'b1;
		end
	end

	// Product ID, big endian chars, bytes swapped on the way in
	always_ff @(posedge clk_sys) begin
		if (hdr_wr_stb) begin
			if (dl_addr == ADDR_W'(cart_pkg::HDR_ID_FIRST_ADDR))
				product_id[63:56] <= hi;
			if (dl_addr == ADDR_W'(cart_pkg::HDR_ID_FIRST_ADDR + 10'd2))
				product_id[55:40] <= {lo, hi};
			if (dl_addr == ADDR_W'(cart_pkg::HDR_ID_FIRST_ADDR + 10'd4))
				product_id[39:24] <= {lo, hi};
			if (dl_addr == ADDR_W'(cart_pkg::HDR_ID_FIRST_ADDR + 10'd6))
				product_id[23:8] <= {lo, hi};
			if (dl_addr == ADDR_W'(cart_pkg::HDR_ID_FIRST_ADDR + 10'd8))
				product_id[7:0] <= lo;
		end
	end

endmodule

`default_nettype wire

// ==== rtl/cart_quirk_lookup.sv ====
`timescale 1ns/1ps
`default_nettype none

module cart_quirk_lookup (
	input  logic                  clk_sys,
	input  logic                  RESET,
	input  logic                  cart_start,
	input  logic                  id_done,
	input  cart_pkg::product_id_t product_id,
	output cart_pkg::quirks_t     quirks,
	output cart_pkg::gun_delay_t  gun_delay
);

	cart_pkg::quirks_t    lut_quirks;
	cart_pkg::gun_delay_t lut_delay;

	////////////////////////////////////////////////////////////
	// Known titles

	always_comb begin
		lut_quirks = '0;
		lut_delay  = cart_pkg::GUN_DELAY_DEFAULT;
		case (product_id)
			"T-081276": lut_quirks.sram   = 1'b1; // Battery save, odd mapping
			"T-81406 ": lut_quirks.sram   = 1'b1;
			"MK-1215 ": lut_quirks.eeprom = 1'b1;
			"G-4060  ": lut_quirks.eeprom = 1'b1;
			"T-113016": lut_quirks.noram  = 1'b1; // Fake RAM check
			"T-89016 ": lut_quirks.fifo   = 1'b1;
			"MK-1229 ": lut_quirks.svp    = 1'b1;
			"T-95096-": begin
				lut_quirks.gun_type = 1'b1; // Justifier style gun
				lut_delay           = 8'd52;
			end
			default: ;
		endcase
	end

	always_ff @(posedge clk_sys) begin
		if (RESET || cart_start) begin
			quirks    <= '0;
			gun_delay <= cart_pkg::GUN_DELAY_DEFAULT;
		end else if (id_done) begin
			quirks    <= lut_quirks;
			gun_delay <= lut_delay;
		end
	end

endmodule

`default_nettype wire

// ==== rtl/rom_write_master.sv ====
`timescale 1ns/1ps
`default_nettype none

module rom_write_master #(
	parameter int ADDR_W = 25
) (
	input  logic                    clk_sys,
	input  logic                    RESET,
	input  logic                    rom_wr_stb,
	input  logic [ADDR_W-1:0]       dl_addr,
	input  rom_bus_pkg::word_t      dl_data,
	output rom_bus_pkg::wb_wr_req_t wb_req,
	output logic [ADDR_W-2:0]       wb_adr,
	input  logic                    wb_ack,
	output logic                    wr_done
);

	typedef enum logic {
		IDLE,
		BUS
	} state_t;

	state_t             state;
	rom_bus_pkg::word_t wr_dat;

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			state <= IDLE;
		end else begin
			case (state)
				IDLE: if (rom_wr_stb) state <= BUS;
				BUS:  if (wb_ack) state <= IDLE; // Single beat, drop next cycle
				default: state <= IDLE;
			endcase
		end
	end

	// Word latch, bytes swapped for the memory
	always_ff @(posedge clk_sys) begin
		if (state == IDLE && rom_wr_stb) begin
			wb_adr <= dl_addr[ADDR_W-1:1];
			wr_dat <= {dl_data[7:0], dl_data[15:8]};
		end
	end

	assign wb_req.cyc = (state == BUS);
	assign wb_req.stb = (state == BUS);
	assign wb_req.we  = 1'b1;
	assign wb_req.sel = '1;
	assign wb_req.dat = wr_dat;

	assign wr_done = (state == BUS) && wb_ack;

	// Slave acks only an open strobed cycle
	a_ack_in_cycle: assert property (@(posedge clk_sys) disable iff (RESET)
		wb_ack |-> wb_req.cyc && wb_req.stb);

	// One write in flight, the host wait must cover the whole cycle
	a_no_stb_in_bus: assert property (@(posedge clk_sys) disable iff (RESET)
		rom_wr_stb |-> state == IDLE);

endmodule

`default_nettype wire

// ==== rtl/cheat_code_loader.sv ====
`timescale 1ns/1ps
`default_nettype none

module cheat_code_loader #(
	parameter int ADDR_W = 25
) (
	input  logic                  clk_sys,
	input  logic                  RESET,
	input  logic                  code_wr_stb,
	input  logic [ADDR_W-1:0]     dl_addr,
	input  rom_bus_pkg::word_t    dl_data,
	output cart_pkg::cheat_code_t code,
	output logic                  code_valid,
	output logic                  code_reset
);

	// Eight words per code, low half of each field first
	always_ff @(posedge clk_sys) begin
		if (code_wr_stb) begin
			case (dl_addr[3:0])
				4'd0:  code.flags[15:0]    <= dl_data;
				4'd2:  code.flags[31:16]   <= dl_data;
				4'd4:  code.address[15:0]  <= dl_data;
				4'd6:  code.address[31:16] <= dl_data;
				4'd8:  code.compare[15:0]  <= dl_data;
				4'd10: code.compare[31:16] <= dl_data;
				4'd12: code.replace[15:0]  <= dl_data;
				4'd14: code.replace[31:16] <= dl_data;
				default: ;
			endcase
		end
	end

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			code_valid <= 1'b0;
			code_reset <= 1'b0;
		end else begin
			code_valid <= code_wr_stb && (dl_addr[3:0] == 4'd14); // Last word of a code
			code_reset <= code_wr_stb && (dl_addr == '0);         // Start of a new list
		end
	end

endmodule

`default_nettype wire

// ==== rtl/cart_loader_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module cart_loader_top #(
	parameter int ADDR_W = 25
) (
	input  logic                    clk_sys,
	input  logic                    RESET,
	input  logic                    dl_active,
	input  logic [7:0]              dl_index,
	input  logic                    dl_wr,
	input  logic [ADDR_W-1:0]       dl_addr,
	input  rom_bus_pkg::word_t      dl_data,
	output logic                    dl_wait,
	input  logic                    region_auto,
	input  cart_pkg::region_t       region_manual,
	input  cart_pkg::region_prio_t  region_prio,
	output rom_bus_pkg::wb_wr_req_t wb_req,
	output logic [ADDR_W-2:0]       wb_adr,
	input  logic                    wb_ack,
	output logic [ADDR_W-1:0]       rom_size,
	output cart_pkg::region_t       region,
	output logic                    region_set,
	output cart_pkg::quirks_t       quirks,
	output cart_pkg::gun_delay_t    gun_delay,
	output cart_pkg::cheat_code_t   code,
	output logic                    code_valid,
	output logic                    code_reset
);

	logic                  rom_wr_stb;
	logic                  hdr_wr_stb;
	logic                  code_wr_stb;
	logic                  cart_start;
	logic                  wr_done;
	logic                  hdr_ready;
	logic                  id_done;
	cart_pkg::hdr_flags_t  hdr_flags;
	cart_pkg::product_id_t product_id;

	////////////////////////////////////////////////////////////
	// Control

	cart_load_ctrl #(.ADDR_W(ADDR_W)) cart_load_ctrl_inst (
		.clk_sys       (clk_sys),
		.RESET         (RESET),
		.dl_active     (dl_active),
		.dl_index      (dl_index),
		.dl_wr         (dl_wr),
		.dl_addr       (dl_addr),
		.wr_done       (wr_done),
		.hdr_ready     (hdr_ready),
		.hdr_flags     (hdr_flags),
		.region_auto   (region_auto),
		.region_manual (region_manual),
		.region_prio   (region_prio),
		.dl_wait       (dl_wait),
		.rom_wr_stb    (rom_wr_stb),
		.hdr_wr_stb    (hdr_wr_stb),
		.code_wr_stb   (code_wr_stb),
		.cart_start    (cart_start),
		.rom_size      (rom_size),
		.region        (region),
		.region_set    (region_set)
	);

	////////////////////////////////////////////////////////////
	// Datapath

	cart_header_scan #(.ADDR_W(ADDR_W)) cart_header_scan_inst (
		.clk_sys    (clk_sys),
		.RESET      (RESET),
		.hdr_wr_stb (hdr_wr_stb),
		.dl_addr    (dl_addr),
		.dl_data    (dl_data),
		.cart_start (cart_start),
		.dl_active  (dl_active),
		.hdr_flags  (hdr_flags),
		.product_id (product_id),
		.id_done    (id_done),
		.hdr_ready  (hdr_ready)
	);

	cart_quirk_lookup cart_quirk_lookup_inst (
		.clk_sys    (clk_sys),
		.RESET      (RESET),
		.cart_start (cart_start),
		.id_done    (id_done),
		.product_id (product_id),
		.quirks     (quirks),
		.gun_delay  (gun_delay)
	);

	rom_write_master #(.ADDR_W(ADDR_W)) rom_write_master_inst (
		.clk_sys    (clk_sys),
		.RESET      (RESET),
		.rom_wr_stb (rom_wr_stb),
		.dl_addr    (dl_addr),
		.dl_data    (dl_data),
		.wb_req     (wb_req),
		.wb_adr     (wb_adr),
		.wb_ack     (wb_ack),
		.wr_done    (wr_done)
	);

	cheat_code_loader #(.ADDR_W(ADDR_W)) cheat_code_loader_inst (
		.clk_sys     (clk_sys),
		.RESET       (RESET),
		.code_wr_stb (code_wr_stb),
		.dl_addr     (dl_addr),
		.dl_data     (dl_data),
		.code        (code),
		.code_valid  (code_valid),
		.code_reset  (code_reset)
	);

endmodule

`default_nettype wire

// ==== bench/tb_rom_slave.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_rom_slave (
	input  logic                    clk_sys,
	input  logic                    RESET,
	input  rom_bus_pkg::wb_wr_req_t wb_req,
	output logic                    wb_ack,
	output int                      write_count
);

	logic [7:0] lfsr;
	logic       busy;
	logic [1:0] wait_left;

	// Fibonacci LFSR, taps 8 6 5 4
	function automatic logic [7:0] lfsr_next(input logic [7:0] s);
		return {s[6:0], s[7] ^ s[5] ^ s[4] ^ s[3]};
	endfunction

	always @(posedge clk_sys) begin
		logic [7:0] s1;
		logic [7:0] s2;
		if (RESET) begin
			wb_ack      <= 1'b0;
			busy        <= 1'b0;
			wait_left   <= 2'd0;
			lfsr        <= 8'd78;
			write_count <= 0;
		end else begin
			wb_ack <= 1'b0;
			if (wb_req.cyc && wb_req.stb && !wb_ack) begin
				if (!busy) begin
					s1 = lfsr_next(lfsr); // One step per wait bit
					s2 = lfsr_next(s1);
					lfsr      <= s2;
					wait_left <= {s1[0], s2[0]};
					busy      <= 1'b1;
				end else if (wait_left == 2'd0) begin
					wb_ack      <= 1'b1;
					busy        <= 1'b0;
					write_count <= write_count + 1;
				end else begin
					wait_left <= wait_left - 2'd1;
				end
			end
		end
	end

endmodule

`default_nettype wire

// ==== bench/tb_cart_loader.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_cart_loader;

	localparam int ADDR_W = 25;

	logic                    clk_sys;
	logic                    RESET;
	logic                    dl_active;
	logic [7:0]              dl_index;
	logic                    dl_wr;
	logic [ADDR_W-1:0]       dl_addr;
	rom_bus_pkg::word_t      dl_data;
	logic                    dl_wait;
	logic                    region_auto;
	cart_pkg::region_t       region_manual;
	cart_pkg::region_prio_t  region_prio;
	rom_bus_pkg::wb_wr_req_t wb_req;
	logic [ADDR_W-2:0]       wb_adr;
	logic                    wb_ack;
	logic [ADDR_W-1:0]       rom_size;
	cart_pkg::region_t       region;
	logic                    region_set;
	cart_pkg::quirks_t       quirks;
	cart_pkg::gun_delay_t    gun_delay;
	cart_pkg::cheat_code_t   code;
	logic                    code_valid;
	logic                    code_reset;
	int                      slave_writes;

	int                      value_errors = 0;
	int                      other_errors = 0;
	int                      ack_count = 0;
	int                      sent_count = 0;
	int                      ncv = 0;
	int                      ncr = 0;
	int                      cycles = 0;
	int                      limit = 0;
	cart_pkg::cheat_code_t   last_code;
	logic [ADDR_W-2:0]       exp_adr[$];
	rom_bus_pkg::word_t      exp_dat[$];

	cart_loader_top #(.ADDR_W(ADDR_W)) cart_loader_top_inst (
		.clk_sys(clk_sys), .RESET(RESET), .dl_active(dl_active), .dl_index(dl_index),
		.dl_wr(dl_wr), .dl_addr(dl_addr), .dl_data(dl_data), .dl_wait(dl_wait),
		.region_auto(region_auto), .region_manual(region_manual),
		.region_prio(region_prio), .wb_req(wb_req), .wb_adr(wb_adr), .wb_ack(wb_ack),
		.rom_size(rom_size), .region(region), .region_set(region_set),
		.quirks(quirks), .gun_delay(gun_delay), .code(code),
		.code_valid(code_valid), .code_reset(code_reset)
	);

	tb_rom_slave rom_slave_inst (
		.clk_sys(clk_sys), .RESET(RESET), .wb_req(wb_req),
		.wb_ack(wb_ack), .write_count(slave_writes)
	);

	always #50 clk_sys = ~clk_sys;

	task automatic compare_value(input string name, input logic [127:0] got,
			input logic [127:0] exp);
		assert (got === exp) else begin
			value_errors++;
			$display("FAILED t=%0t %s got %0h expected %0h", $time, name, got, exp);
		end
	endtask

	task automatic verify_condition(input string what, input logic cond);
		assert (cond === 1'b1) else begin
			other_errors++;
			$display("ERROR t=%0t %s", $time, what);
		end
	endtask

	////////////////////////////////////////////////////////////
	// Bus and pulse monitor

	always @(posedge clk_sys) begin
		cycles++;
		if (limit > 0 && cycles > limit) begin
			$display("Timeout: run did not finish within %0d cycles", limit);
			$display("Done: errors found");
			$finish;
		end else if (!RESET) begin
			if (wb_ack && wb_req.cyc) begin
				ack_count++;
				if (exp_adr.size() == 0) begin
					verify_condition("bus write seen with no cartridge write pending", 1'b0);
				end else begin
					compare_value("wb_adr", 128'(wb_adr), 128'(exp_adr.pop_front()));
					compare_value("wb_req.dat", 128'(wb_req.dat), 128'(exp_dat.pop_front()));
					compare_value("wb_req.stb", 128'(wb_req.stb), 128'(1'b1));
					compare_value("wb_req.sel", 128'(wb_req.sel), 128'(2'b11));
					compare_value("wb_req.we", 128'(wb_req.we), 128'(1'b1));
				end
			end
			if (code_valid) begin
				ncv++;
				last_code = code;
			end
			if (code_reset)
				ncr++;
		end
	end

	////////////////////////////////////////////////////////////
	// Host driver

	task automatic begin_download(input logic [7:0] idx);
		dl_index  = idx;
		dl_active = 1'b1;
		@(posedge clk_sys);
		#5;
	endtask

	task automatic write_word(input logic [ADDR_W-1:0] a, input rom_bus_pkg::word_t d);
		logic cart;
		cart = (dl_index != 8'hFF);
		if (cart) begin
			exp_adr.push_back((ADDR_W-1)'(a / 2)); // Word address
			exp_dat.push_back((d << 8) | (d >> 8)); // Memory takes swapped bytes
			sent_count++;
		end
		dl_addr = a;
		dl_data = d;
		dl_wr   = 1'b1;
		@(posedge clk_sys);
		#5;
		dl_wr = 1'b0;
		if (cart)
			verify_condition("dl_wait did not rise after a cartridge write", dl_wait);
		else
			verify_condition("dl_wait rose during a cheat stream", !dl_wait);
		while (dl_wait) begin
			@(posedge clk_sys);
			#5;
		end
		compare_value("acked writes", 128'(ack_count), 128'(sent_count));
	endtask

	task automatic end_download;
		dl_active = 1'b0;
		repeat (2) @(posedge clk_sys);
		#5;
	endtask

	task automatic expect_value(input string nm, input logic [127:0] v);
		if (nm == "size") begin
			compare_value("rom_size", 128'(rom_size), v);
		end else if (nm == "region") begin
			compare_value("region", 128'(region), v);
			compare_value("region_set", 128'(region_set), 128'(1'b1));
		end else if (nm == "quirks") begin
			compare_value("quirks", 128'(quirks), v);
		end else if (nm == "delay") begin
			compare_value("gun_delay", 128'(gun_delay), v);
		end else if (nm == "ncr") begin
			compare_value("code_reset pulses", 128'(ncr), v);
		end else if (nm == "ncv") begin
			compare_value("code_valid pulses", 128'(ncv), v);
		end else if (nm == "code") begin
			compare_value("code", 128'(last_code), v);
		end else begin
			verify_condition("unknown name in an expect line", 1'b0);
		end
	endtask

	task automatic run_command(input string line);
		string        cmd;
		string        nm;
		logic [127:0] v1;
		logic [127:0] v2;
		logic [127:0] v3;
		v1 = '0;
		v2 = '0;
		v3 = '0;
		void'($sscanf(line, "%s", cmd));
		if (cmd == "B") begin
			void'($sscanf(line, "%s %h", cmd, v1));
			begin_download(v1[7:0]);
		end else if (cmd == "W") begin
			void'($sscanf(line, "%s %h %h", cmd, v1, v2));
			write_word(v1[ADDR_W-1:0], v2[15:0]);
		end else if (cmd == "E") begin
			end_download();
		end else if (cmd == "R") begin
			void'($sscanf(line, "%s %h %h %h", cmd, v1, v2, v3));
			region_auto   = v1[0];
			region_manual = cart_pkg::region_t'(v2[1:0]);
			region_prio   = cart_pkg::region_prio_t'(v3[1:0]);
		end else if (cmd == "X") begin
			void'($sscanf(line, "%s %s %h", cmd, nm, v1));
			expect_value(nm, v1);
		end else begin
			verify_condition("unknown command in the stimulus file", 1'b0);
		end
	endtask

	initial begin
		int    fd;
		int    n_cmds;
		string line;
		clk_sys = 1'b0;
		RESET = 1'b1;
		dl_active = 1'b0;
		dl_index = 8'h00;
		dl_wr = 1'b0;
		dl_addr = '0;
		dl_data = '0;
		region_auto = 1'b1;
		region_manual = cart_pkg::JP;
		region_prio = cart_pkg::PRIO_UEJ;
		n_cmds = 0;

		fd = $fopen("bench/cart_stim.txt", "r");
		if (fd == 0) begin
			$display("Cannot open bench/cart_stim.txt");
			$display("Done: errors found");
			$finish;
		end else begin
			while ($fgets(line, fd) > 0)
				if (line.len() > 1 && line[0] != "#")
					n_cmds++;
			$fclose(fd);
			limit = n_cmds * 12 + 64; // 12 cycles per command covers worst slave
			fd = $fopen("bench/cart_stim.txt", "r");

			repeat (16) @(posedge clk_sys);
			#5;
			RESET = 1'b0;
			verify_condition("dl_wait high after reset", !dl_wait);
			verify_condition("cyc or stb high after reset", !wb_req.cyc && !wb_req.stb);
			verify_condition("region_set high after reset", !region_set);
			verify_condition("code pulse high after reset", !code_valid && !code_reset);
			compare_value("quirks", 128'(quirks), 128'(0));

			while ($fgets(line, fd) > 0)
				if (line.len() > 1 && line[0] != "#")
					run_command(line);
			$fclose(fd);

			verify_condition("cartridge writes never reached the bus", exp_adr.size() == 0);
			compare_value("slave write count", 128'(slave_writes), 128'(sent_count));
			$display("Errors: %0d value, %0d other", value_errors, other_errors);
			if (value_errors == 0 && other_errors == 0)
				$display("Done: no errors");
			else
				$display("Done: errors found");
			$finish;
		end
	end

endmodule

`default_nettype wire

// ==== bench/cart_stim.txt ====
# B index | W byte_addr data | E | R auto manual prio | X name value (all hex)
# Names: size region quirks delay ncr ncv code
B 00
W 000000 1234
W 000002 ABCD
W 000182 5400
W 000184 392D
W 000186 3035
W 000188 3639
W 00018A 002D
W 00018C 0000
X quirks 01
X delay 34
E
X size 18C
B 00
X quirks 00
X delay 2C
W 000182 5400
W 000184 302D
W 000186 3138
W 000188 3732
W 00018A 0036
W 00018C 0000
X quirks 20
X delay 2C
E
B 00
W 000182 4100
W 00018C 0000
X quirks 00
X delay 2C
E
X size 18C
# Header J and E letters
R 1 0 0
B 00
W 0001F0 454A
W 000200 0000
X region 2
E
R 1 0 1
B 00
W 0001F0 454A
W 000200 0000
X region 2
E
R 1 0 2
B 00
W 0001F0 454A
W 000200 0000
X region 0
E
R 1 0 3
B 00
W 0001F0 454A
W 000200 0000
X region 0
E
# Header hex digit C
R 1 0 0
B 00
W 0001F0 2043
W 000200 0000
X region 1
E
R 1 0 1
B 00
W 0001F0 2043
W 000200 0000
X region 2
E
R 1 0 2
B 00
W 0001F0 2043
W 000200 0000
X region 1
E
R 1 0 3
B 00
W 0001F0 2043
W 000200 0000
X region 1
E
# No region code
R 1 0 0
B 00
W 0001F0 2020
W 000200 0000
X region 1
E
R 1 0 1
B 00
W 0001F0 2020
W 000200 0000
X region 2
E
R 1 0 2
B 00
W 0001F0 2020
W 000200 0000
X region 1
E
R 1 0 3
B 00
W 0001F0 2020
W 000200 0000
X region 0
E
R 0 0 0
B 00
W 0001F0 2020
W 000200 0000
X region 0
E
X size 200
# Cheat stream
B FF
W 000000 0001
W 000002 0000
W 000004 1234
W 000006 00FF
W 000008 ABCD
W 00000A 0000
W 00000C 5A5A
W 00000E 0000
E
X ncr 1
X ncv 1
X code 0000000100FF12340000ABCD00005A5A
X size 200

// ==== compile.f ====
rtl/cart_pkg.sv
rtl/rom_bus_pkg.sv
rtl/cart_load_ctrl.sv
rtl/cart_header_scan.sv
rtl/cart_quirk_lookup.sv
rtl/rom_write_master.sv
rtl/cheat_code_loader.sv
rtl/cart_loader_top.sv
bench/tb_rom_slave.sv
bench/tb_cart_loader.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_cart_loader
BUILD     ?= obj_dir
FILELIST  ?= compile.f
VFLAGS    ?= --binary --timing --assert
PASS      ?= Done: no errors

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee /dev/stderr | grep -q "$(PASS)"

clean:
	rm -rf $(BUILD)
